/* Bender.yml */
package:
  name: crc_ahb

sources:
  - src/crc_pkg.sv
  - src/crc_host_interface.sv
  - src/crc_data_buffer.sv
  - src/crc_engine.sv
  - src/crc_ahb_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/crc_tb.sv

/* project.f */
+incdir+sim
src/crc_pkg.sv
src/crc_host_interface.sv
src/crc_data_buffer.sv
src/crc_engine.sv
src/crc_ahb_top.sv
sim/crc_tb.sv

/* sim/crc_ref_model.svh */
`ifndef CRC_REF_MODEL_SVH
`define CRC_REF_MODEL_SVH

// Register shadow
crc_cfg_t    cfg_shadow;
logic [31:0] init_shadow;
logic [31:0] pol_shadow;
logic [7:0]  idr_shadow;
logic [31:0] crc_shadow;

function automatic void shadow_reset();
	cfg_shadow  = '0;
	init_shadow = 32'hFFFF_FFFF;
	pol_shadow  = 32'h04C1_1DB7;
	idr_shadow  = 8'h00;
	crc_shadow  = 32'hFFFF_FFFF;
endfunction

// CRC width in bits for a poly_size code
function automatic int poly_width(input logic [1:0] poly_size);
	case (poly_size)
		2'd0: return 32;
		2'd1: return 16;
		2'd2: return 8;
		default: return 7;
	endcase
endfunction

function automatic logic [31:0] width_mask(input int w);
	return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 32'h1);
endfunction

// Mirror bits w-1..0
function automatic logic [31:0] mirror_low(input logic [31:0] d, input int w);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < w; i++)
		r[i] = d[w - 1 - i];
	return r;
endfunction

// Reverse groups of g bits inside a u-bit unit, g never wider than u
function automatic logic [31:0] reverse_input(input logic [31:0] d, input int u,
	input logic [1:0] rev_in);
	logic [31:0] r;
	int          g;
	case (rev_in)
		2'd1: g = 8;
		2'd2: g = 16;
		2'd3: g = 32;
		default: g = 1;
	endcase
	if (g > u)
		g = u;
	r = '0;
	for (int i = 0; i < u; i++)
		r[i] = d[(i / g) * g + g - 1 - (i % g)];
	return r;
endfunction

// Bit-serial CRC, u data bits taken MSB first
function automatic logic [31:0] crc_feed(input logic [31:0] crc, input logic [31:0] d,
	input int u, input logic [31:0] poly, input int w);
	logic [31:0] c;
	logic [31:0] m;
	logic        fb;
	m = width_mask(w);
	c = crc & m;
	for (int i = u - 1; i >= 0; i--)
	begin
		fb = c[w - 1] ^ d[i];
		c  = (c << 1) & m;
		if (fb)
			c = c ^ (poly & m);
	end
	return c;
endfunction

function automatic void track_write(input logic [2:0] idx, input logic [31:0] data,
	input logic [2:0] size);
	int u;
	int w;
	u = 8 << size[1:0];
	w = poly_width(cfg_shadow.poly_size);
	case (idx)
		CRC_DR:
			crc_shadow = crc_feed(crc_shadow, reverse_input(data, u, cfg_shadow.rev_in),
				u, pol_shadow, w);
		CRC_IDR:
			idr_shadow = data[7:0];
		CRC_CR:
		begin
			cfg_shadow = crc_cfg_t'(data[7:3]);
			// Reset pulse reloads the CRC from INIT
			if (data[0])
				crc_shadow = init_shadow;
		end
		CRC_INIT:
		begin
			init_shadow = data;
			crc_shadow  = data;
		end
		CRC_POL:
			pol_shadow = data;
		default:
			;
	endcase
endfunction

function automatic logic [31:0] expected_dr();
	int          w;
	logic [31:0] v;
	w = poly_width(cfg_shadow.poly_size);
	v = crc_shadow & width_mask(w);
	return cfg_shadow.rev_out ? mirror_low(v, w) : v;
endfunction

`endif

/* sim/crc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module crc_tb;
	import crc_pkg::*;

	logic        HCLK;
	logic        HRESETn;
	logic [31:0] HADDR;
	logic [31:0] HWDATA;
	logic [2:0]  HSIZE;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic        HSELx;
	wire         HREADY;
	wire  [31:0] HRDATA;
	wire         HREADYOUT;
	wire         HRESP;

	int          stall_cycles;
	logic [2:0]  reg_list [5] = '{CRC_DR, CRC_IDR, CRC_CR, CRC_INIT, CRC_POL};

	`include "crc_ref_model.svh"

	// Only one slave on the bus
	assign HREADY = HREADYOUT;

	crc_ahb_top dut
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HADDR     (HADDR),
		.HWDATA    (HWDATA),
		.HSIZE     (HSIZE),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSELx     (HSELx),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	initial
	begin
		HCLK = 1'b0;
		forever #5 HCLK = ~HCLK;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERROR: %s got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	function automatic logic [31:0] reg_addr(input logic [2:0] idx);
		return {27'h0, idx, 2'b00};
	endfunction

	// Entered just after a rising edge, returns just after the edge ending the data phase
	task automatic bus_transfer(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [2:0] size, input logic write, input logic [1:0] trans, input logic sel,
		output logic [31:0] rdata);
		int waited;
		HADDR  <= addr;
		HWRITE <= write;
		HSIZE  <= size;
		HTRANS <= trans;
		HSELx  <= sel;
		@(posedge HCLK);
		HTRANS <= HTRANS_IDLE;
		HSELx  <= 1'b0;
		HWDATA <= wdata;
		waited = 0;
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			stall_cycles++;
			waited++;
			if (waited > 64)
				fail_run($sformatf("Timeout waiting for HREADYOUT on a transfer to 0x%08h",
					addr));
			@(negedge HCLK);
		end
		rdata = HRDATA;
		check_equal("HRESP", {31'h0, HRESP}, 32'h0);
		@(posedge HCLK);
	endtask

	task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [2:0] size);
		logic [31:0] unused;
		bus_transfer(addr, data, size, 1'b1, HTRANS_NONSEQ, 1'b1, unused);
	endtask

	task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
		bus_transfer(addr, 32'h0, 3'd2, 1'b0, HTRANS_NONSEQ, 1'b1, data);
	endtask

	task automatic reg_write(input logic [2:0] idx, input logic [31:0] data,
		input logic [2:0] size);
		ahb_write(reg_addr(idx), data, size);
		track_write(idx, data, size);
	endtask

	task automatic read_check(input logic [2:0] idx, input string name,
		input logic [31:0] exp);
		logic [31:0] rd;
		ahb_read(reg_addr(idx), rd);
		check_equal(name, rd, exp);
	endtask

	task automatic compare_all_regs();
		read_check(CRC_DR, "DR", expected_dr());
		read_check(CRC_IDR, "IDR", {24'h0, idr_shadow});
		read_check(CRC_CR, "CR", {24'h0, cfg_shadow, 3'b000});
		read_check(CRC_INIT, "INIT", init_shadow);
		read_check(CRC_POL, "POL", pol_shadow);
	endtask

	initial
	begin
		logic [31:0] seed_ret;
		logic [31:0] rd;
		logic [2:0]  idx;
		int          n;
		seed_ret = $urandom(2207);
		HRESETn = 1'b0;
		HADDR   = 32'h0;
		HWDATA  = 32'h0;
		HSIZE   = 3'd0;
		HTRANS  = HTRANS_IDLE;
		HWRITE  = 1'b0;
		HSELx   = 1'b0;
		stall_cycles = 0;
		shadow_reset();
		repeat (8) @(posedge HCLK);
		HRESETn <= 1'b1;

		// Reset values
		read_check(CRC_CR, "CR", 32'h0);
		read_check(CRC_IDR, "IDR", 32'h0);
		read_check(CRC_INIT, "INIT", 32'hFFFF_FFFF);
		read_check(CRC_POL, "POL", 32'h04C1_1DB7);
		read_check(CRC_DR, "DR", 32'hFFFF_FFFF);

		repeat (20)
		begin
			reg_write(CRC_IDR, $urandom(), 3'd2);
			reg_write(CRC_POL, $urandom(), 3'd2);
			reg_write(CRC_INIT, $urandom(), 3'd2);
			reg_write(CRC_CR, $urandom(), 3'd2);
			compare_all_regs();
		end

		// Random configurations and data streams
		repeat (200)
		begin
			reg_write(CRC_POL, $urandom(), 3'd2);
			reg_write(CRC_INIT, $urandom(), 3'd2);
			reg_write(CRC_CR, ($urandom() & 32'hF8) | 32'h1, 3'd2);
			n = $urandom_range(1, 12);
			repeat (n)
				reg_write(CRC_DR, $urandom(), 3'($urandom_range(0, 2)));
			read_check(CRC_DR, "DR", expected_dr());
		end

		// Word writes faster than the engine drains them
		reg_write(CRC_CR, 32'h1, 3'd2);
		stall_cycles = 0;
		repeat (6)
			reg_write(CRC_DR, $urandom(), 3'd2);
		if (stall_cycles == 0)
			fail_run("No wait state seen during back-to-back DR word writes");
		read_check(CRC_DR, "DR", expected_dr());

		// Reset pulse while data is still in flight
		repeat (8)
		begin
			reg_write(CRC_POL, $urandom(), 3'd2);
			reg_write(CRC_INIT, $urandom(), 3'd2);
			reg_write(CRC_CR, ($urandom() & 32'hF8) | 32'h1, 3'd2);
			repeat (3)
				reg_write(CRC_DR, $urandom(), 3'd2);
			reg_write(CRC_CR, {24'h0, cfg_shadow, 3'b001}, 3'd2);
			read_check(CRC_DR, "DR", expected_dr());
		end

		// IDLE, BUSY and unselected transfers
		for (int k = 0; k < 30; k++)
		begin
			idx = reg_list[$urandom_range(0, 4)];
			case (k % 3)
				0: bus_transfer(reg_addr(idx), $urandom(), 3'd2, 1'b1, HTRANS_IDLE, 1'b1, rd);
				1: bus_transfer(reg_addr(idx), $urandom(), 3'd2, 1'b1, HTRANS_BUSY, 1'b1, rd);
				default:
					bus_transfer(reg_addr(idx), $urandom(), 3'd2, 1'b1, HTRANS_NONSEQ, 1'b0, rd);
			endcase
		end
		compare_all_regs();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src/crc_ahb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module crc_ahb_top
(
	input  wire         HCLK,
	input  wire         HRESETn,
	input  wire  [31:0] HADDR,
	input  wire  [31:0] HWDATA,
	input  wire  [2:0]  HSIZE,
	input  wire  [1:0]  HTRANS,
	input  wire         HWRITE,
	input  wire         HSELx,
	input  wire         HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);
	import crc_pkg::*;

	crc_cfg_t    cfg;
	data_entry_t push_entry;
	data_entry_t head;
	logic [31:0] wr_data;
	logic        push;
	logic        pop;
	logic        full;
	logic        empty;
	logic        busy;
	logic        init_we;
	logic        idr_we;
	logic        poly_we;
	logic        reset_chain;
	logic [31:0] crc_value;
	logic [31:0] init_value;
	logic [31:0] poly_value;
	logic [7:0]  idr_value;

	crc_host_interface u_host
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.HADDR       (HADDR),
		.HWDATA      (HWDATA),
		.HSIZE       (HSIZE),
		.HTRANS      (HTRANS),
		.HWRITE      (HWRITE),
		.HSELx       (HSELx),
		.HREADY      (HREADY),
		.HRDATA      (HRDATA),
		.HREADYOUT   (HREADYOUT),
		.HRESP       (HRESP),
		.cfg         (cfg),
		.wr_data     (wr_data),
		.push        (push),
		.push_entry  (push_entry),
		.full        (full),
		.empty       (empty),
		.busy        (busy),
		.crc_value   (crc_value),
		.init_value  (init_value),
		.poly_value  (poly_value),
		.idr_value   (idr_value),
		.init_we     (init_we),
		.idr_we      (idr_we),
		.poly_we     (poly_we),
		.reset_chain (reset_chain)
	);

	// CR reset pulse also drops anything still queued
	crc_data_buffer u_buffer
	(
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.flush      (reset_chain),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.head       (head),
		.full       (full),
		.empty      (empty)
	);

	crc_engine u_engine
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.cfg         (cfg),
		.wr_data     (wr_data),
		.init_we     (init_we),
		.idr_we      (idr_we),
		.poly_we     (poly_we),
		.reset_chain (reset_chain),
		.head        (head),
		.empty       (empty),
		.pop         (pop),
		.busy        (busy),
		.crc_value   (crc_value),
		.init_value  (init_value),
		.poly_value  (poly_value),
		.idr_value   (idr_value)
	);

endmodule

`default_nettype wire

/* src/crc_data_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module crc_data_buffer
(
	input  wire                   HCLK,
	input  wire                   HRESETn,
	input  wire                   flush,
	input  wire                   push,
	input  crc_pkg::data_entry_t  push_entry,
	input  wire                   pop,
	output crc_pkg::data_entry_t  head,
	output logic                  full,
	output logic                  empty
);
	import crc_pkg::*;

	data_entry_t       mem [BUF_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// Wrap at the last slot
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(BUF_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (push)
			mem[wr_ptr] <= push_entry;
	end

	assign head  = mem[rd_ptr];
	assign full  = (count == CNT_W'(BUF_DEPTH));
	assign empty = (count == '0);

	a_no_pop_when_empty: assert property (@(posedge HCLK) disable iff (!HRESETn)
		pop |-> !empty)
		else $error("Pop from an empty buffer");

endmodule

`default_nettype wire

/* src/crc_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module crc_engine
(
	input  wire                   HCLK,
	input  wire                   HRESETn,
	input  crc_pkg::crc_cfg_t     cfg,
	input  wire  [31:0]           wr_data,
	input  wire                   init_we,
	input  wire                   idr_we,
	input  wire                   poly_we,
	input  wire                   reset_chain,
	input  crc_pkg::data_entry_t  head,
	input  wire                   empty,
	output logic                  pop,
	output logic                  busy,
	output logic [31:0]           crc_value,
	output logic [31:0]           init_value,
	output logic [31:0]           poly_value,
	output logic [7:0]            idr_value
);
	import crc_pkg::*;

	logic [31:0] init_reg;
	logic [31:0] poly_reg;
	logic [7:0]  idr_reg;
	logic [31:0] crc_reg;
	logic [31:0] shift_reg;
	logic [2:0]  byte_cnt;
	logic [4:0]  top;
	logic [31:0] mask;
	logic [31:0] crc_masked;
	logic [1:0]  unit_lvl;
	logic [1:0]  rev_lvl;
	logic [31:0] rev_data;
	logic [31:0] load_shift;
	logic [2:0]  load_cnt;

	// Bit i takes bit i^flip, so flip 7/15/31 reverses bytes/halfwords/word
	function automatic logic [31:0] reflect(input logic [31:0] d, input logic [4:0] flip);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[5'(i) ^ flip];
		return r;
	endfunction

	// Reverse only bits top..0
	function automatic logic [31:0] rev_width(input logic [31:0] d, input logic [4:0] msb);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < 32; i++)
			if (5'(i) <= msb)
				r[i] = d[msb - 5'(i)];
		return r;
	endfunction

	// Eight MSB-first steps of the LFSR
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] din,
		input logic [31:0] poly, input logic [31:0] m, input logic [4:0] msb);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[msb] ^ din[i];
			c  = (c << 1) & m;
			if (fb)
				c = c ^ (poly & m);
		end
		return c;
	endfunction

	always_comb
	begin
		case (cfg.poly_size)
			2'd0: top = 5'd31;
			2'd1: top = 5'd15;
			2'd2: top = 5'd7;
			default: top = 5'd6;
		endcase
		mask = 32'hFFFF_FFFF >> (5'd31 - top);
	end

	// Granularity levels 1..3 are byte, halfword, word; clip to the unit
	always_comb
	begin
		unit_lvl = (head.size == 2'd0) ? 2'd1 : (head.size == 2'd1) ? 2'd2 : 2'd3;
		rev_lvl  = (cfg.rev_in > unit_lvl) ? unit_lvl : cfg.rev_in;
		case (rev_lvl)
			2'd1: rev_data = reflect(head.data, 5'd7);
			2'd2: rev_data = reflect(head.data, 5'd15);
			2'd3: rev_data = reflect(head.data, 5'd31);
			default: rev_data = head.data;
		endcase
		case (unit_lvl)
			2'd1:
			begin
				load_shift = {rev_data[7:0], 24'h0};
				load_cnt   = 3'd1;
			end
			2'd2:
			begin
				load_shift = {rev_data[15:0], 16'h0};
				load_cnt   = 3'd2;
			end
			default:
			begin
				load_shift = rev_data;
				load_cnt   = 3'd4;
			end
		endcase
	end

	assign busy = (byte_cnt != 3'd0);
	// A reset pulse flushes the buffer in the same cycle
	assign pop  = !empty && !busy && !reset_chain;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_reg <= RESET_INIT;
			poly_reg <= RESET_POL;
			idr_reg  <= 8'h00;
		end
		else
		begin
			if (init_we)
				init_reg <= wr_data;
			if (poly_we)
				poly_reg <= wr_data;
			if (idr_we)
				idr_reg <= wr_data[7:0];
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_reg  <= RESET_INIT;
			byte_cnt <= 3'd0;
		end
		else if (reset_chain)
		begin
			crc_reg  <= init_reg;
			byte_cnt <= 3'd0;
		end
		else if (init_we)
			crc_reg <= wr_data;
		else if (pop)
			byte_cnt <= load_cnt;
		else if (busy)
		begin
			crc_reg  <= crc_byte(crc_reg, shift_reg[31:24], poly_reg, mask, top);
			byte_cnt <= byte_cnt - 3'd1;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (pop)
			shift_reg <= load_shift;
		else if (busy)
			shift_reg <= shift_reg << 8;
	end

	assign crc_masked = crc_reg & mask;
	assign crc_value  = cfg.rev_out ? rev_width(crc_masked, top) : crc_masked;
	assign init_value = init_reg;
	assign poly_value = poly_reg;
	assign idr_value  = idr_reg;

endmodule

`default_nettype wire

/* src/crc_host_interface.sv */
`timescale 1ns/1ns
`default_nettype none

module crc_host_interface
(
	input  wire                   HCLK,
	input  wire                   HRESETn,
	input  wire  [31:0]           HADDR,
	input  wire  [31:0]           HWDATA,
	input  wire  [2:0]            HSIZE,
	input  wire  [1:0]            HTRANS,
	input  wire                   HWRITE,
	input  wire                   HSELx,
	input  wire                   HREADY,
	output logic [31:0]           HRDATA,
	output logic                  HREADYOUT,
	output logic                  HRESP,
	output crc_pkg::crc_cfg_t     cfg,
	output logic [31:0]           wr_data,
	output logic                  push,
	output crc_pkg::data_entry_t  push_entry,
	input  wire                   full,
	input  wire                   empty,
	input  wire                   busy,
	input  wire  [31:0]           crc_value,
	input  wire  [31:0]           init_value,
	input  wire  [31:0]           poly_value,
	input  wire  [7:0]            idr_value,
	output logic                  init_we,
	output logic                  idr_we,
	output logic                  poly_we,
	output logic                  reset_chain
);
	import crc_pkg::*;

	// Address phase pipeline
	logic [2:0] haddr_pp;
	logic [1:0] hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hsel_pp;

	crc_cfg_t   cfg_q;
	logic       sample_bus;
	logic       write_en;
	logic       read_en;
	logic       dr_wr;
	logic       dr_rd;
	logic       init_wr;
	logic       cr_wr;
	logic       engine_idle;

	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_pp   <= 1'b0;
			htrans_pp <= HTRANS_IDLE;
			hwrite_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hsel_pp   <= HSELx;
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= HADDR[4:2];
			hsize_pp <= HSIZE[1:0];
		end
	end

	// Only NONSEQ starts an access
	assign write_en = hsel_pp && hwrite_pp && (htrans_pp == HTRANS_NONSEQ);
	assign read_en  = hsel_pp && !hwrite_pp && (htrans_pp == HTRANS_NONSEQ);

	assign dr_wr   = write_en && (haddr_pp == CRC_DR);
	assign dr_rd   = read_en && (haddr_pp == CRC_DR);
	assign init_wr = write_en && (haddr_pp == CRC_INIT);
	assign cr_wr   = write_en && (haddr_pp == CRC_CR);

	// Nothing queued and nothing in flight
	assign engine_idle = empty && !busy;

	assign HREADYOUT = !((dr_wr && full) || (dr_rd && !engine_idle) || (init_wr && !engine_idle));
	assign HRESP     = 1'b0;

	// Strobes fire on the last cycle of the data phase
	assign push        = dr_wr && HREADYOUT;
	assign init_we     = init_wr && HREADYOUT;
	assign idr_we      = write_en && (haddr_pp == CRC_IDR) && HREADYOUT;
	assign poly_we     = write_en && (haddr_pp == CRC_POL) && HREADYOUT;
	assign reset_chain = cr_wr && HWDATA[0] && HREADYOUT;

	assign wr_data         = HWDATA;
	assign push_entry.data = HWDATA;
	assign push_entry.size = hsize_pp;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg_q <= crc_cfg_t'(RESET_CR);
		else if (cr_wr && HREADYOUT)
			cfg_q <= crc_cfg_t'(HWDATA[7:3]);
	end

	assign cfg = cfg_q;

	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = crc_value;
			CRC_IDR:  HRDATA = {24'h0, idr_value};
			CRC_CR:   HRDATA = {24'h0, cfg_q, 3'b000};
			CRC_INIT: HRDATA = init_value;
			CRC_POL:  HRDATA = poly_value;
			default:  HRDATA = '0;
		endcase
	end

	a_no_push_when_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
		push |-> !full)
		else $error("DR entry pushed into a full buffer");

endmodule

`default_nettype wire

/* src/crc_pkg.sv */
`default_nettype none

package crc_pkg;

	// Register indices taken from HADDR[4:2]
	localparam logic [2:0] CRC_DR   = 3'd0;
	localparam logic [2:0] CRC_IDR  = 3'd1;
	localparam logic [2:0] CRC_CR   = 3'd2;
	localparam logic [2:0] CRC_INIT = 3'd4;
	localparam logic [2:0] CRC_POL  = 3'd5;

	// AHB transfer types
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// Register reset values
	localparam logic [4:0]  RESET_CR   = 5'h00;
	localparam logic [31:0] RESET_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_POL  = 32'h04C1_1DB7;

	// Data buffer sizing
	localparam int BUF_DEPTH = 2;
	localparam int PTR_W     = $clog2(BUF_DEPTH);
	localparam int CNT_W     = $clog2(BUF_DEPTH + 1);

	// Field order matches CR bits 7:3
	typedef struct packed {
		logic       rev_out;
		logic [1:0] rev_in;
		logic [1:0] poly_size;
	} crc_cfg_t;

	// One DR write, data in the low bits
	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  size;
	} data_entry_t;

endpackage

`default_nettype wire
